// ==== pipe_config.svh ====
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Datapath width in bits
`define XLEN 64

// Architectural register count
`define NUM_REGS 32

// Data memory depth in doublewords
`define DMEM_WORDS 256

// Program counter after reset
`define RESET_PC 0

// Data memory word i starts at this base plus i
`define DMEM_INIT_BASE 'h1000

`endif

// ==== rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    `include "pipe_config.svh"

    typedef logic [`XLEN-1:0] xword_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [31:0] instr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        f3_add_sub = 3'b000,
        f3_ld_sd   = 3'b011,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_e;

    // beq shares the add/sub funct3 encoding
    localparam funct3_e f3_beq = f3_add_sub;

endpackage

`default_nettype wire

// ==== rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;

    // Operations the execute ALU performs
    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or
    } alu_op_e;

    // Source of an execute operand
    typedef enum logic [1:0] {
        fwd_reg,
        fwd_exmem,
        fwd_memwb
    } fwd_sel_e;

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module fetch_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  wire rv_isa_pkg::instr_t instruction,
    input  wire                     stall,
    input  wire                     redirect,
    input  wire rv_isa_pkg::xword_t target,
    output rv_isa_pkg::xword_t      pc,
    output rv_isa_pkg::instr_t      ifid_instr,
    output rv_isa_pkg::xword_t      ifid_pc
);

    // Program counter, a taken branch overrides a stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= rv_isa_pkg::xword_t'(`RESET_PC);
        end else if (redirect) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pc + 4;
        end
    end

    // An all-zero word decodes to no controls and acts as the bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ifid_instr <= '0;
        end else if (redirect) begin
            ifid_instr <= '0;
        end else if (!stall) begin
            ifid_instr <= instruction;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid_pc <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module decode_stage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire rv_isa_pkg::instr_t   ifid_instr,
    input  wire rv_isa_pkg::xword_t   ifid_pc,
    input  wire                       redirect,
    input  wire                       wb_valid,
    input  wire rv_isa_pkg::reg_idx_t wb_rd,
    input  wire rv_isa_pkg::xword_t   wb_data,
    output logic                      stall,
    output rv_isa_pkg::xword_t        idex_pc,
    output rv_isa_pkg::reg_idx_t      idex_rs1,
    output rv_isa_pkg::reg_idx_t      idex_rs2,
    output rv_isa_pkg::xword_t        idex_val1,
    output rv_isa_pkg::xword_t        idex_val2,
    output rv_isa_pkg::xword_t        idex_imm,
    output rv_isa_pkg::reg_idx_t      idex_rd,
    output rv_pipe_pkg::alu_op_e      idex_alu_op,
    output logic                      idex_alu_src,
    output logic                      idex_mem_read,
    output logic                      idex_mem_write,
    output logic                      idex_reg_write,
    output logic                      idex_mem_to_reg,
    output logic                      idex_branch
);

    rv_isa_pkg::opcode_e  opcode;
    rv_isa_pkg::funct3_e  funct3;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::xword_t   imm;
    rv_isa_pkg::xword_t   val1;
    rv_isa_pkg::xword_t   val2;
    rv_isa_pkg::xword_t   regs [`NUM_REGS];
    rv_pipe_pkg::alu_op_e alu_op;
    logic alu_src;
    logic mem_read;
    logic mem_write;
    logic reg_write;
    logic mem_to_reg;
    logic branch;

    assign opcode = rv_isa_pkg::opcode_e'(ifid_instr[6:0]);
    assign funct3 = rv_isa_pkg::funct3_e'(ifid_instr[14:12]);
    assign rd     = ifid_instr[11:7];
    assign rs1    = ifid_instr[19:15];
    assign rs2    = ifid_instr[24:20];

    // Immediate by format: S for stores, B for branches, I otherwise
    always_comb begin
        case (opcode)
            rv_isa_pkg::op_store: begin
                imm = {{(`XLEN-12){ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
            end
            rv_isa_pkg::op_branch: begin
                imm = {{(`XLEN-13){ifid_instr[31]}}, ifid_instr[31], ifid_instr[7],
                       ifid_instr[30:25], ifid_instr[11:8], 1'b0};
            end
            default: begin
                imm = {{(`XLEN-12){ifid_instr[31]}}, ifid_instr[31:20]};
            end
        endcase
    end

    always_comb begin
        alu_op     = rv_pipe_pkg::alu_add;
        alu_src    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        branch     = 1'b0;
        case (opcode)
            rv_isa_pkg::op_reg: begin
                reg_write = 1'b1;
                case (funct3)
                    // funct7 bit 5 tells sub from add
                    rv_isa_pkg::f3_add_sub: begin
                        alu_op = ifid_instr[30] ? rv_pipe_pkg::alu_sub : rv_pipe_pkg::alu_add;
                    end
                    rv_isa_pkg::f3_and: alu_op = rv_pipe_pkg::alu_and;
                    rv_isa_pkg::f3_or:  alu_op = rv_pipe_pkg::alu_or;
                    default: reg_write = 1'b0;
                endcase
            end
            rv_isa_pkg::op_imm: begin
                alu_src   = 1'b1;
                reg_write = (funct3 == rv_isa_pkg::f3_add_sub);
            end
            rv_isa_pkg::op_load: begin
                alu_src    = 1'b1;
                mem_read   = (funct3 == rv_isa_pkg::f3_ld_sd);
                reg_write  = mem_read;
                mem_to_reg = 1'b1;
            end
            rv_isa_pkg::op_store: begin
                alu_src   = 1'b1;
                mem_write = (funct3 == rv_isa_pkg::f3_ld_sd);
            end
            rv_isa_pkg::op_branch: begin
                branch = (funct3 == rv_isa_pkg::f3_beq);
            end
            default: ;
        endcase
    end

    // Register file, every entry comes out of reset holding its own index
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= rv_isa_pkg::xword_t'(i);
            end
        end else if (wb_valid) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Same-cycle write is visible to the read
    assign val1 = (wb_valid && wb_rd == rs1) ? wb_data : regs[rs1];
    assign val2 = (wb_valid && wb_rd == rs2) ? wb_data : regs[rs2];

    // Load in ID/EX feeding the instruction in IF/ID
    assign stall = idex_mem_read && idex_rd != '0 && (idex_rd == rs1 || idex_rd == rs2);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex_mem_read   <= 1'b0;
            idex_mem_write  <= 1'b0;
            idex_reg_write  <= 1'b0;
            idex_mem_to_reg <= 1'b0;
            idex_branch     <= 1'b0;
        end else if (stall || redirect) begin
            idex_mem_read   <= 1'b0;
            idex_mem_write  <= 1'b0;
            idex_reg_write  <= 1'b0;
            idex_mem_to_reg <= 1'b0;
            idex_branch     <= 1'b0;
        end else begin
            idex_mem_read   <= mem_read;
            idex_mem_write  <= mem_write;
            idex_reg_write  <= reg_write;
            idex_mem_to_reg <= mem_to_reg;
            idex_branch     <= branch;
        end
    end

    always_ff @(posedge clk) begin
        idex_pc      <= ifid_pc;
        idex_rs1     <= rs1;
        idex_rs2     <= rs2;
        idex_val1    <= val1;
        idex_val2    <= val2;
        idex_imm     <= imm;
        idex_rd      <= rd;
        idex_alu_op  <= alu_op;
        idex_alu_src <= alu_src;
    end

endmodule

`default_nettype wire

// ==== operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  wire rv_isa_pkg::reg_idx_t src_rs,
    input  wire rv_isa_pkg::xword_t   src_val,
    input  wire rv_isa_pkg::reg_idx_t exmem_rd,
    input  wire                       exmem_reg_write,
    input  wire rv_isa_pkg::xword_t   exmem_result,
    input  wire rv_isa_pkg::reg_idx_t memwb_rd,
    input  wire                       memwb_reg_write,
    input  wire rv_isa_pkg::xword_t   wb_data,
    output rv_isa_pkg::xword_t        operand
);

    rv_pipe_pkg::fwd_sel_e sel;

    // The younger result wins, x0 always reads as stored
    always_comb begin
        if (src_rs == '0) begin
            sel = rv_pipe_pkg::fwd_reg;
        end else if (exmem_reg_write && exmem_rd == src_rs) begin
            sel = rv_pipe_pkg::fwd_exmem;
        end else if (memwb_reg_write && memwb_rd == src_rs) begin
            sel = rv_pipe_pkg::fwd_memwb;
        end else begin
            sel = rv_pipe_pkg::fwd_reg;
        end
    end

    always_comb begin
        case (sel)
            rv_pipe_pkg::fwd_exmem: operand = exmem_result;
            rv_pipe_pkg::fwd_memwb: operand = wb_data;
            default:                operand = src_val;
        endcase
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire rv_isa_pkg::xword_t   idex_pc,
    input  wire rv_isa_pkg::xword_t   idex_imm,
    input  wire rv_isa_pkg::reg_idx_t idex_rd,
    input  wire rv_pipe_pkg::alu_op_e idex_alu_op,
    input  wire                       idex_alu_src,
    input  wire                       idex_mem_read,
    input  wire                       idex_mem_write,
    input  wire                       idex_reg_write,
    input  wire                       idex_mem_to_reg,
    input  wire                       idex_branch,
    input  wire rv_isa_pkg::xword_t   operand1,
    input  wire rv_isa_pkg::xword_t   operand2,
    output logic                      redirect,
    output rv_isa_pkg::xword_t        target,
    output rv_isa_pkg::xword_t        exmem_result,
    output rv_isa_pkg::xword_t        exmem_store_val,
    output rv_isa_pkg::reg_idx_t      exmem_rd,
    output logic                      exmem_reg_write,
    output logic                      exmem_mem_read,
    output logic                      exmem_mem_write,
    output logic                      exmem_mem_to_reg
);

    rv_isa_pkg::xword_t operand_b;
    rv_isa_pkg::xword_t alu_result;

    assign operand_b = idex_alu_src ? idex_imm : operand2;

    always_comb begin
        case (idex_alu_op)
            rv_pipe_pkg::alu_sub: alu_result = operand1 - operand_b;
            rv_pipe_pkg::alu_and: alu_result = operand1 & operand_b;
            rv_pipe_pkg::alu_or:  alu_result = operand1 | operand_b;
            default:              alu_result = operand1 + operand_b;
        endcase
    end

    // beq resolves here on the forwarded register values
    assign redirect = idex_branch && (operand1 == operand2);
    assign target   = idex_pc + idex_imm;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem_reg_write  <= 1'b0;
            exmem_mem_read   <= 1'b0;
            exmem_mem_write  <= 1'b0;
            exmem_mem_to_reg <= 1'b0;
        end else begin
            exmem_reg_write  <= idex_reg_write;
            exmem_mem_read   <= idex_mem_read;
            exmem_mem_write  <= idex_mem_write;
            exmem_mem_to_reg <= idex_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        exmem_result    <= alu_result;
        exmem_store_val <= operand2;
        exmem_rd        <= idex_rd;
    end

endmodule

`default_nettype wire

// ==== memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module memory_stage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire rv_isa_pkg::xword_t   exmem_result,
    input  wire rv_isa_pkg::xword_t   exmem_store_val,
    input  wire rv_isa_pkg::reg_idx_t exmem_rd,
    input  wire                       exmem_reg_write,
    input  wire                       exmem_mem_read,
    input  wire                       exmem_mem_write,
    input  wire                       exmem_mem_to_reg,
    output logic                      wb_valid,
    output rv_isa_pkg::reg_idx_t      wb_rd,
    output rv_isa_pkg::xword_t        wb_data,
    output rv_isa_pkg::reg_idx_t      memwb_rd,
    output logic                      memwb_reg_write
);

    localparam int addr_w = $clog2(`DMEM_WORDS);

    rv_isa_pkg::xword_t dmem [`DMEM_WORDS];
    rv_isa_pkg::xword_t load_data;
    rv_isa_pkg::xword_t memwb_load_data;
    rv_isa_pkg::xword_t memwb_result;
    logic [addr_w-1:0]  word_addr;
    logic               memwb_mem_to_reg;

    // Doubleword index, byte offset bits dropped
    assign word_addr = exmem_result[addr_w+2:3];
    assign load_data = exmem_mem_read ? dmem[word_addr] : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= rv_isa_pkg::xword_t'(`DMEM_INIT_BASE + i);
            end
        end else if (exmem_mem_write) begin
            dmem[word_addr] <= exmem_store_val;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memwb_reg_write  <= 1'b0;
            memwb_mem_to_reg <= 1'b0;
        end else begin
            memwb_reg_write  <= exmem_reg_write;
            memwb_mem_to_reg <= exmem_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        memwb_rd        <= exmem_rd;
        memwb_result    <= exmem_result;
        memwb_load_data <= load_data;
    end

    // Writes to x0 are dropped here
    assign wb_valid = memwb_reg_write && memwb_rd != '0;
    assign wb_rd    = memwb_rd;
    assign wb_data  = memwb_mem_to_reg ? memwb_load_data : memwb_result;

endmodule

`default_nettype wire

// ==== rv_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline (
    input  wire                     clk,
    input  wire                     reset,
    input  wire rv_isa_pkg::instr_t instruction,
    output rv_isa_pkg::xword_t      pc,
    output logic                    wb_valid,
    output rv_isa_pkg::reg_idx_t    wb_rd,
    output rv_isa_pkg::xword_t      wb_data
);

    rv_isa_pkg::instr_t   ifid_instr;
    rv_isa_pkg::xword_t   ifid_pc;
    rv_isa_pkg::xword_t   target;
    rv_isa_pkg::xword_t   idex_pc;
    rv_isa_pkg::xword_t   idex_val1;
    rv_isa_pkg::xword_t   idex_val2;
    rv_isa_pkg::xword_t   idex_imm;
    rv_isa_pkg::reg_idx_t idex_rs1;
    rv_isa_pkg::reg_idx_t idex_rs2;
    rv_isa_pkg::reg_idx_t idex_rd;
    rv_pipe_pkg::alu_op_e idex_alu_op;
    rv_isa_pkg::xword_t   fwd_operand [2];
    rv_isa_pkg::xword_t   exmem_result;
    rv_isa_pkg::xword_t   exmem_store_val;
    rv_isa_pkg::reg_idx_t exmem_rd;
    rv_isa_pkg::reg_idx_t memwb_rd;
    logic stall;
    logic redirect;
    logic idex_alu_src;
    logic idex_mem_read;
    logic idex_mem_write;
    logic idex_reg_write;
    logic idex_mem_to_reg;
    logic idex_branch;
    logic exmem_reg_write;
    logic exmem_mem_read;
    logic exmem_mem_write;
    logic exmem_mem_to_reg;
    logic memwb_reg_write;

    fetch_stage u_fetch (
        .clk(clk), .reset(reset), .instruction(instruction),
        .stall(stall), .redirect(redirect), .target(target),
        .pc(pc), .ifid_instr(ifid_instr), .ifid_pc(ifid_pc)
    );

    decode_stage u_decode (
        .clk(clk), .reset(reset), .ifid_instr(ifid_instr), .ifid_pc(ifid_pc),
        .redirect(redirect), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .stall(stall), .idex_pc(idex_pc), .idex_rs1(idex_rs1), .idex_rs2(idex_rs2),
        .idex_val1(idex_val1), .idex_val2(idex_val2), .idex_imm(idex_imm),
        .idex_rd(idex_rd), .idex_alu_op(idex_alu_op), .idex_alu_src(idex_alu_src),
        .idex_mem_read(idex_mem_read), .idex_mem_write(idex_mem_write),
        .idex_reg_write(idex_reg_write), .idex_mem_to_reg(idex_mem_to_reg),
        .idex_branch(idex_branch)
    );

    // Operand 0 follows rs1, operand 1 follows rs2
    for (genvar i = 0; i < 2; i++) begin : g_fwd
        operand_forward u_fwd (
            .src_rs(i == 0 ? idex_rs1 : idex_rs2),
            .src_val(i == 0 ? idex_val1 : idex_val2),
            .exmem_rd(exmem_rd), .exmem_reg_write(exmem_reg_write),
            .exmem_result(exmem_result), .memwb_rd(memwb_rd),
            .memwb_reg_write(memwb_reg_write), .wb_data(wb_data),
            .operand(fwd_operand[i])
        );
    end

    execute_stage u_execute (
        .clk(clk), .reset(reset), .idex_pc(idex_pc), .idex_imm(idex_imm),
        .idex_rd(idex_rd), .idex_alu_op(idex_alu_op), .idex_alu_src(idex_alu_src),
        .idex_mem_read(idex_mem_read), .idex_mem_write(idex_mem_write),
        .idex_reg_write(idex_reg_write), .idex_mem_to_reg(idex_mem_to_reg),
        .idex_branch(idex_branch), .operand1(fwd_operand[0]), .operand2(fwd_operand[1]),
        .redirect(redirect), .target(target), .exmem_result(exmem_result),
        .exmem_store_val(exmem_store_val), .exmem_rd(exmem_rd),
        .exmem_reg_write(exmem_reg_write), .exmem_mem_read(exmem_mem_read),
        .exmem_mem_write(exmem_mem_write), .exmem_mem_to_reg(exmem_mem_to_reg)
    );

    memory_stage u_memory (
        .clk(clk), .reset(reset), .exmem_result(exmem_result),
        .exmem_store_val(exmem_store_val), .exmem_rd(exmem_rd),
        .exmem_reg_write(exmem_reg_write), .exmem_mem_read(exmem_mem_read),
        .exmem_mem_write(exmem_mem_write), .exmem_mem_to_reg(exmem_mem_to_reg),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .memwb_rd(memwb_rd), .memwb_reg_write(memwb_reg_write)
    );

endmodule

`default_nettype wire

// ==== clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Release lands a quarter period after a rising edge, clear of both edges
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #(period / 4);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_rv_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module tb_rv_pipeline;

    localparam int max_words     = 128;
    localparam int reset_timeout = 20;
    localparam int wb_timeout    = 50;
    localparam int quiet_cycles  = 20;

    // addi x0, x0, 0
    localparam rv_isa_pkg::instr_t nop_word = 32'h0000_0013;

    logic                 clk;
    logic                 reset;
    rv_isa_pkg::instr_t   instruction;
    rv_isa_pkg::xword_t   pc;
    logic                 wb_valid;
    rv_isa_pkg::reg_idx_t wb_rd;
    rv_isa_pkg::xword_t   wb_data;

    // Cases file image: program length, program, entry count, entries
    logic [63:0] case_words [max_words];
    int          prog_len;
    int          exp_base;
    int          exp_count;

    clock_gen u_clock_gen (.clk(clk), .reset(reset));

    rv_pipeline u_rv_pipeline (
        .clk(clk), .reset(reset), .instruction(instruction), .pc(pc),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_reg_idx(input string name, input rv_isa_pkg::reg_idx_t actual,
                                 input rv_isa_pkg::reg_idx_t expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_word(input string name, input rv_isa_pkg::xword_t actual,
                              input rv_isa_pkg::xword_t expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%016h, expected 0x%016h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    // Program word at a byte address, nop past the end of the program
    function automatic rv_isa_pkg::instr_t fetch_word(input rv_isa_pkg::xword_t addr);
        rv_isa_pkg::xword_t index;
        index = addr >> 2;
        if (index < rv_isa_pkg::xword_t'(prog_len)) begin
            return case_words[1 + int'(index)][31:0];
        end
        return nop_word;
    endfunction

    task automatic load_cases();
        for (int i = 0; i < max_words; i++) begin
            case_words[i] = '0;
        end
        $readmemh("pipeline_cases.txt", case_words);
        prog_len = int'(case_words[0]);
        if (prog_len < 1 || prog_len > max_words - 2) begin
            $display("Cases file is missing or holds a bad program length");
            stop_with_failure();
        end else begin
            exp_count = int'(case_words[prog_len + 1]);
            exp_base  = prog_len + 2;
            if (exp_count < 1 || exp_base + 2 * exp_count > max_words) begin
                $display("Cases file holds a bad count of expected write-backs");
                stop_with_failure();
            end
        end
    endtask

    task automatic wait_for_writeback(input int entry);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_valid && cycles < wb_timeout);
        if (!wb_valid) begin
            $display("No write-back arrived within %0d cycles for entry %0d", wb_timeout, entry);
            stop_with_failure();
        end
    endtask

    // pc only moves on rising edges, so the falling edge sees a settled address
    initial begin
        instruction = nop_word;
        forever begin
            @(negedge clk);
            instruction = fetch_word(pc);
        end
    end

    initial begin
        int                   cycles;
        logic                 extra_seen;
        rv_isa_pkg::reg_idx_t extra_rd;
        rv_isa_pkg::xword_t   extra_data;
        prog_len   = 0;
        exp_count  = 0;
        exp_base   = 0;
        extra_seen = 1'b0;
        extra_rd   = '0;
        extra_data = '0;
        load_cases();

        // Through reset and the first falling edge after release
        cycles = 0;
        do begin
            @(negedge clk);
            check_word("pc", pc, rv_isa_pkg::xword_t'(`RESET_PC));
            check_bit("wb_valid", wb_valid, 1'b0);
            cycles++;
        end while (reset && cycles <= reset_timeout);
        if (reset) begin
            $display("Reset was still asserted after %0d cycles", reset_timeout);
            stop_with_failure();
        end

        for (int k = 0; k < exp_count; k++) begin
            wait_for_writeback(k);
            check_reg_idx("wb_rd", wb_rd, rv_isa_pkg::reg_idx_t'(case_words[exp_base + 2 * k]));
            check_word("wb_data", wb_data, case_words[exp_base + 2 * k + 1]);
        end

        // Flushed and trailing instructions must stay silent
        for (int n = 0; n < quiet_cycles; n++) begin
            @(negedge clk);
            if (wb_valid) begin
                extra_seen = 1'b1;
                extra_rd   = wb_rd;
                extra_data = wb_data;
                break;
            end
        end
        if (extra_seen) begin
            $display("Unexpected write-back after the last entry: x%0d = 0x%016h",
                     extra_rd, extra_data);
            stop_with_failure();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== pipeline_cases.txt ====
// Program: word count, then one instruction word per line, word i at address 4*i
// Expected write-backs: entry count, then register index and 64-bit value per line
14
00208533 // add  x10, x1, x2
02050593 // addi x11, x10, 0x20
40a58633 // sub  x12, x11, x10
00b676b3 // and  x13, x12, x11
0056e733 // or   x14, x13, x5
fff70793 // addi x15, x14, -1
40e08833 // sub  x16, x1, x14
01003883 // ld   x17, 16(x0)
00388933 // add  x18, x17, x3
03003423 // sd   x16, 40(x0)
02803983 // ld   x19, 40(x0)
00208463 // beq  x1, x2, +8 not taken
05500a13 // addi x20, x0, 0x55
014a0663 // beq  x20, x20, +12 taken
06600a93 // addi x21, x0, 0x66 flushed
07700b13 // addi x22, x0, 0x77 flushed
001a0b93 // addi x23, x20, 1
00000463 // beq  x0, x0, +8 taken
09900c13 // addi x24, x0, 0x99 flushed
011b8cb3 // add  x25, x23, x17
0d
0a 0000000000000003
0b 0000000000000023
0c 0000000000000020
0d 0000000000000020
0e 0000000000000025
0f 0000000000000024
10 ffffffffffffffdc
11 0000000000001002
12 0000000000001005
13 ffffffffffffffdc
14 0000000000000055
17 0000000000000056
19 0000000000001058

// ==== all.f ====
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
operand_forward.sv
execute_stage.sv
memory_stage.sv
rv_pipeline.sv
clock_gen.sv
tb_rv_pipeline.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f all.f --top-module tb_rv_pipeline \
    --Mdir obj_dir -o tb_rv_pipeline &&
./obj_dir/tb_rv_pipeline || exit 1
